// ==== sim.f ====
lsu_pkg.sv
load_skid_buffer.sv
load_fifo.sv
load_data_ram.sv
load_align.sv
load_queue.sv
load_unit_top.sv
tb_load_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load unit simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_load_unit \
    -o tb_load_unit_sim > build.log 2>&1 &&
./obj_dir/tb_load_unit_sim > sim.log 2>&1 ;
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && echo "PASS" && exit 0 ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== tb_load_unit.sv ====
// Testbench for the load unit
// Random cached and I/O loads against an SRAM mirror and an I/O responder model,
// SRAM write collisions, flush, writeback checks and a watchdog

`timescale 1ns/1ps

module tb_load_unit import lsu_pkg::*; ();

    localparam int TOTAL_LOADS = 204;
    localparam int FILL_LINES  = 512;

    logic core_clock_i, arst_n_i, flush_i, lsu_vld_i, lsu_busy_o;
    rob_tag_t lsu_rob_i, wb_rob_o, tag_cnt;
    load_op_t lsu_op_i, io_op_o;
    addr_t lsu_addr_i, io_addr_o;
    phys_reg_t lsu_dest_i, wb_dest_o;
    oldest_tag_t oldest_rob_i;
    logic io_req_o, io_ack_i, wb_vld_o, wb_wr_en_o, ram_wr_en_i;
    word_t io_rdata_i, wb_data_o;
    ram_index_t ram_wr_index_i;
    dword_t ram_wr_data_i;

    // Reference model state
    integer seed;
    dword_t mirror [512];
    logic tbl_pending [64];
    addr_t tbl_addr [64];
    load_op_t tbl_op [64];
    phys_reg_t tbl_dest [64];
    logic used5 [32];
    rob_tag_t io_q [$];
    int outstanding, errors, checks, test_err;
    logic req_checked;

    load_unit_top u_dut (.*);

    initial begin
        core_clock_i = 1'b0;
        forever #20 core_clock_i = ~core_clock_i;
    end

    initial begin
        repeat (TOTAL_LOADS * 12 + 400 + FILL_LINES) @(posedge core_clock_i);
        $display("Timeout, loads did not complete in time");
        $display("Simulation failed");
        $finish;
    end

    // Byte, half or word from a 32-bit word, then sign or zero extension
    function automatic word_t extend_load(input word_t w, input logic [1:0] off,
                                          input load_op_t op);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        if (op[1:0] == 2'd0) return op[2] ? word_t'(b) : 32'($signed(b));
        if (op[1:0] == 2'd1) return op[2] ? word_t'(h) : 32'($signed(h));
        return w;
    endfunction

    always @(posedge core_clock_i) begin
        if (ram_wr_en_i) mirror[ram_wr_index_i] = ram_wr_data_i;
    end

    // Oldest tag is the oldest I/O load not yet written back
    always @(posedge core_clock_i) begin
        #2;
        oldest_rob_i = (io_q.size() != 0) ? io_q[0][4:0] : '0;
    end

    // I/O responder, 1 to 4 cycles per request
    initial begin
        int w;
        forever begin
            @(posedge core_clock_i);
            #2;
            if (arst_n_i && io_req_o && !io_ack_i) begin
                w = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
                repeat (w) begin
                    @(posedge core_clock_i);
                    #2;
                end
                io_ack_i   = 1'b1;
                io_rdata_i = io_addr_o ^ 32'h5a5a_a5a5;
                @(posedge core_clock_i);
                #2;
                io_ack_i = 1'b0;
            end
        end
    end

    task automatic check_outputs;
        rob_tag_t t;
        word_t    w;
        word_t    exp;
        logic     exp_en;
        if (io_req_o && !req_checked) begin
            checks++;
            if (io_q.size() == 0) begin
                errors++;
                $display("I/O request at %h with no I/O load waiting", io_addr_o);
            end else begin
                if (io_addr_o !== tbl_addr[io_q[0]]) begin
                    errors++;
                    $display("CHECK FAILED io_addr_o got %h expected %h",
                             io_addr_o, tbl_addr[io_q[0]]);
                end
                if (io_op_o !== tbl_op[io_q[0]]) begin
                    errors++;
                    $display("CHECK FAILED io_op_o got %h expected %h",
                             io_op_o, tbl_op[io_q[0]]);
                end
            end
            req_checked = 1'b1;
        end
        if (io_ack_i) req_checked = 1'b0;
        if (!wb_vld_o && wb_wr_en_o !== 1'b0) begin
            errors++;
            $display("CHECK FAILED wb_wr_en_o got %h expected %h without writeback",
                     wb_wr_en_o, 1'b0);
        end
        if (wb_vld_o) begin
            t = wb_rob_o;
            checks++;
            if (!tbl_pending[t]) begin
                errors++;
                $display("Writeback for tag %h that has no pending load", t);
            end else begin
                if (tbl_addr[t][IO_SPACE_BIT]) begin
                    w = tbl_addr[t] ^ 32'h5a5a_a5a5;
                    if (io_q.size() == 0 || io_q[0] !== t) begin
                        errors++;
                        $display("I/O load with tag %h wrote back out of order", t);
                    end else begin
                        void'(io_q.pop_front());
                    end
                end else begin
                    w = tbl_addr[t][2] ? mirror[tbl_addr[t][11:3]][63:32]
                                       : mirror[tbl_addr[t][11:3]][31:0];
                end
                exp = extend_load(w, tbl_addr[t][1:0], tbl_op[t]);
                if (wb_data_o !== exp) begin
                    errors++;
                    $display("CHECK FAILED wb_data_o tag %h got %h expected %h",
                             t, wb_data_o, exp);
                end
                if (wb_dest_o !== tbl_dest[t]) begin
                    errors++;
                    $display("CHECK FAILED wb_dest_o tag %h got %h expected %h",
                             t, wb_dest_o, tbl_dest[t]);
                end
                // Register 0 is never written
                exp_en = (tbl_dest[t] != '0);
                if (wb_wr_en_o !== exp_en) begin
                    errors++;
                    $display("CHECK FAILED wb_wr_en_o tag %h got %h expected %h",
                             t, wb_wr_en_o, exp_en);
                end
                tbl_pending[t] = 1'b0;
                used5[t[4:0]]  = 1'b0;
                outstanding--;
            end
        end
    endtask

    always @(negedge core_clock_i) begin
        if (arst_n_i) check_outputs();
    end

    task automatic send_load(input logic io, input logic narrow, input logic zero_dest);
        logic [31:0] r;
        while (used5[tag_cnt[4:0]]) begin
            @(posedge core_clock_i);
            #2;
        end
        r = $random(seed);
        r[31] = io;
        if (narrow) r[30:6] = '0;
        lsu_addr_i = r;
        lsu_rob_i  = tag_cnt;
        r = $random(seed);
        lsu_op_i   = {r[2], (r[1:0] == 2'd3) ? 2'd2 : r[1:0]};
        lsu_dest_i = (zero_dest && r[11]) ? '0 : r[10:5];
        lsu_vld_i  = 1'b1;
        while (lsu_busy_o) begin
            @(posedge core_clock_i);
            #2;
        end
        tbl_pending[tag_cnt] = 1'b1;
        tbl_addr[tag_cnt]    = lsu_addr_i;
        tbl_op[tag_cnt]      = lsu_op_i;
        tbl_dest[tag_cnt]    = lsu_dest_i;
        used5[tag_cnt[4:0]]  = 1'b1;
        if (io) io_q.push_back(tag_cnt);
        outstanding++;
        tag_cnt++;
        @(posedge core_clock_i);
        #2;
        lsu_vld_i = 1'b0;
    endtask

    task automatic run_loads(input int n, input logic io_mix, input logic narrow,
                             input logic zero_dest);
        logic [31:0] r;
        repeat (n) begin
            r = $random(seed);
            send_load(io_mix & r[0], narrow, zero_dest);
        end
    endtask

    task automatic drain;
        while (outstanding != 0) @(posedge core_clock_i);
        #2;
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial begin
        seed = 32'h6d9d;
        arst_n_i = 1'b0;
        {flush_i, lsu_vld_i, io_ack_i, ram_wr_en_i} = '0;
        {lsu_rob_i, lsu_op_i, lsu_addr_i, lsu_dest_i, oldest_rob_i} = '0;
        {io_rdata_i, ram_wr_index_i, ram_wr_data_i, tag_cnt} = '0;
        {outstanding, errors, checks, test_err} = '0;
        req_checked = 1'b0;
        for (int i = 0; i < 64; i++) tbl_pending[i] = 1'b0;
        for (int i = 0; i < 32; i++) used5[i] = 1'b0;
        repeat (5) @(posedge core_clock_i);
        #2;
        arst_n_i = 1'b1;
        checks++;
        if (lsu_busy_o || io_req_o || wb_vld_o || wb_wr_en_o) begin
            errors++;
            $display("Outputs not idle after reset");
        end
        for (int i = 0; i < FILL_LINES; i++) begin
            ram_wr_en_i    = 1'b1;
            ram_wr_index_i = i[8:0];
            ram_wr_data_i  = {$random(seed), $random(seed)};
            @(posedge core_clock_i);
            #2;
        end
        ram_wr_en_i = 1'b0;
        run_loads(40, 1'b0, 1'b0, 1'b0);
        drain();
        report_test("cached loads");
        run_loads(30, 1'b0, 1'b0, 1'b1);
        drain();
        report_test("writeback enable");
        run_loads(40, 1'b1, 1'b0, 1'b0);
        drain();
        report_test("I/O ordering");
        fork
            run_loads(60, 1'b1, 1'b1, 1'b0);
            begin
                logic [31:0] r;
                repeat (200) begin
                    r = $random(seed);
                    ram_wr_en_i    = (r[1:0] == 2'd0);
                    ram_wr_index_i = {6'd0, r[4:2]};
                    ram_wr_data_i  = {$random(seed), $random(seed)};
                    @(posedge core_clock_i);
                    #2;
                end
                ram_wr_en_i = 1'b0;
            end
        join
        drain();
        report_test("collision and busy");
        repeat (4) send_load(1'b1, 1'b0, 1'b0);
        while (!io_req_o) begin
            @(posedge core_clock_i);
            #2;
        end
        flush_i = 1'b1;
        @(posedge core_clock_i);
        for (int i = 0; i < 64; i++) tbl_pending[i] = 1'b0;
        for (int i = 0; i < 32; i++) used5[i] = 1'b0;
        io_q.delete();
        outstanding = 0;
        #2;
        flush_i = 1'b0;
        run_loads(30, 1'b1, 1'b0, 1'b0);
        drain();
        repeat (10) @(posedge core_clock_i);
        report_test("flush");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== load_unit_top.sv ====
// Load unit top level
// Joins the load queue with the data SRAM, SRAM writes double as collisions

`timescale 1ns/1ps

module load_unit_top
    import lsu_pkg::*;
(
    input  logic        core_clock_i,
    input  logic        arst_n_i,
    input  logic        flush_i,
    input  logic        lsu_vld_i,
    input  rob_tag_t    lsu_rob_i,
    input  load_op_t    lsu_op_i,
    input  addr_t       lsu_addr_i,
    input  phys_reg_t   lsu_dest_i,
    output logic        lsu_busy_o,
    input  oldest_tag_t oldest_rob_i,
    output logic        io_req_o,
    output addr_t       io_addr_o,
    output load_op_t    io_op_o,
    input  logic        io_ack_i,
    input  word_t       io_rdata_i,
    output logic        wb_vld_o,
    output rob_tag_t    wb_rob_o,
    output phys_reg_t   wb_dest_o,
    output logic        wb_wr_en_o,
    output word_t       wb_data_o,
    input  logic        ram_wr_en_i,
    input  ram_index_t  ram_wr_index_i,
    input  dword_t      ram_wr_data_i
);

    logic       ram_rd_en;
    ram_index_t ram_rd_index;
    dword_t     ram_rd_data;

    load_queue u_load_queue (
        .core_clock_i    (core_clock_i),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .lsu_vld_i       (lsu_vld_i),
        .lsu_rob_i       (lsu_rob_i),
        .lsu_op_i        (lsu_op_i),
        .lsu_addr_i      (lsu_addr_i),
        .lsu_dest_i      (lsu_dest_i),
        .lsu_busy_o      (lsu_busy_o),
        .oldest_rob_i    (oldest_rob_i),
        .ram_collision_i (ram_wr_en_i),
        .ram_rd_en_o     (ram_rd_en),
        .ram_rd_index_o  (ram_rd_index),
        .ram_rd_data_i   (ram_rd_data),
        .io_req_o        (io_req_o),
        .io_addr_o       (io_addr_o),
        .io_op_o         (io_op_o),
        .io_ack_i        (io_ack_i),
        .io_rdata_i      (io_rdata_i),
        .wb_vld_o        (wb_vld_o),
        .wb_rob_o        (wb_rob_o),
        .wb_dest_o       (wb_dest_o),
        .wb_wr_en_o      (wb_wr_en_o),
        .wb_data_o       (wb_data_o)
    );

    load_data_ram u_data_ram (
        .core_clock_i (core_clock_i),
        .wr_en_i      (ram_wr_en_i),
        .wr_index_i   (ram_wr_index_i),
        .wr_data_i    (ram_wr_data_i),
        .rd_en_i      (ram_rd_en),
        .rd_index_i   (ram_rd_index),
        .rd_data_o    (ram_rd_data)
    );

endmodule

// ==== load_queue.sv ====
// Load queue
// Skid buffer on the request side, cached/I-O steering, in-order I/O queue,
// I/O request FSM, collision and flush handling, writeback stage

`timescale 1ns/1ps

module load_queue
    import lsu_pkg::*;
(
    input  logic        core_clock_i,
    input  logic        arst_n_i,
    input  logic        flush_i,
    input  logic        lsu_vld_i,
    input  rob_tag_t    lsu_rob_i,
    input  load_op_t    lsu_op_i,
    input  addr_t       lsu_addr_i,
    input  phys_reg_t   lsu_dest_i,
    output logic        lsu_busy_o,
    input  oldest_tag_t oldest_rob_i,
    input  logic        ram_collision_i,
    output logic        ram_rd_en_o,
    output ram_index_t  ram_rd_index_o,
    input  dword_t      ram_rd_data_i,
    output logic        io_req_o,
    output addr_t       io_addr_o,
    output load_op_t    io_op_o,
    input  logic        io_ack_i,
    input  word_t       io_rdata_i,
    output logic        wb_vld_o,
    output rob_tag_t    wb_rob_o,
    output phys_reg_t   wb_dest_o,
    output logic        wb_wr_en_o,
    output word_t       wb_data_o
);

    logic [LOAD_REQ_WIDTH-1:0] head_req;
    logic [LOAD_REQ_WIDTH-1:0] io_req_data;
    logic      head_vld;
    rob_tag_t  head_rob, io_rob;
    load_op_t  head_op, io_op;
    addr_t     head_addr, io_addr;
    phys_reg_t head_dest, io_dest;
    logic      head_is_io, stall;
    logic      cached_issue, io_push, io_pop, io_empty, io_full;
    logic      io_issue, io_done, wb_load_io, drop_pending;
    io_state_t io_state;

    logic       wb_vld, wb_from_io;
    load_op_t   wb_op;
    logic [2:0] wb_addr_low;
    word_t      wb_io_data;

    assign head_is_io = head_addr[IO_SPACE_BIT];
    // I/O loads wait on queue space, cached loads on the SRAM and writeback stage
    assign stall = head_vld && (head_is_io ? io_full : (ram_collision_i || io_ack_i));

    load_skid_buffer #(.WIDTH(LOAD_REQ_WIDTH)) u_skid (
        .core_clock_i (core_clock_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .in_vld_i     (lsu_vld_i),
        .in_data_i    ({lsu_rob_i, lsu_op_i, lsu_addr_i, lsu_dest_i}),
        .stall_i      (stall),
        .busy_o       (lsu_busy_o),
        .out_vld_o    (head_vld),
        .out_data_o   (head_req)
    );
    assign {head_rob, head_op, head_addr, head_dest} = head_req;

    assign cached_issue   = head_vld && !head_is_io && !stall && !flush_i;
    assign io_push        = head_vld && head_is_io && !stall && !flush_i;
    assign ram_rd_en_o    = cached_issue;
    assign ram_rd_index_o = head_addr[11:3];

    load_fifo #(.DEPTH(IO_QUEUE_DEPTH), .WIDTH(LOAD_REQ_WIDTH)) u_io_fifo (
        .core_clock_i (core_clock_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .push_i       (io_push),
        .push_data_i  (head_req),
        .pop_i        (io_pop),
        .head_data_o  (io_req_data),
        .empty_o      (io_empty),
        .full_o       (io_full)
    );
    assign {io_rob, io_op, io_addr, io_dest} = io_req_data;

    // Issue only the oldest instruction to the I/O port
    assign io_issue   = (io_state == IO_IDLE) && !io_empty && !flush_i &&
                        (io_rob[4:0] == oldest_rob_i);
    assign io_done    = (io_state == IO_WAIT) && io_ack_i;
    assign wb_load_io = io_done && !drop_pending && !flush_i;
    assign io_pop     = wb_load_io;
    assign io_req_o   = (io_state == IO_WAIT);

    always_ff @(posedge core_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            io_state     <= IO_IDLE;
            drop_pending <= 1'b0;
        end else begin
            if (io_issue) begin
                io_state <= IO_WAIT;
            end else if (io_done) begin
                io_state <= IO_IDLE;
            end
            // A flushed request still completes on the port, its result is dropped
            if (io_done) begin
                drop_pending <= 1'b0;
            end else if (flush_i && io_state == IO_WAIT) begin
                drop_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (io_issue) begin
            io_addr_o <= io_addr;
            io_op_o   <= io_op;
        end
    end

    // Writeback stage
    always_ff @(posedge core_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_vld <= 1'b0;
        end else begin
            wb_vld <= cached_issue || wb_load_io;
        end
    end

    always_ff @(posedge core_clock_i) begin
        wb_from_io <= wb_load_io;
        wb_io_data <= io_rdata_i;
        if (wb_load_io) begin
            wb_rob_o    <= io_rob;
            wb_dest_o   <= io_dest;
            wb_op       <= io_op;
            wb_addr_low <= io_addr[2:0];
        end else begin
            wb_rob_o    <= head_rob;
            wb_dest_o   <= head_dest;
            wb_op       <= head_op;
            wb_addr_low <= head_addr[2:0];
        end
    end

    load_align u_align (
        .from_io_i  (wb_from_io),
        .io_data_i  (wb_io_data),
        .ram_data_i (ram_rd_data_i),
        .addr_low_i (wb_addr_low),
        .op_i       (wb_op),
        .result_o   (wb_data_o)
    );

    assign wb_vld_o   = wb_vld;
    assign wb_wr_en_o = wb_vld && (wb_dest_o != '0);

    a_io_addr_held: assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
        io_req_o && !io_ack_i |=> io_req_o && $stable(io_addr_o));
    a_no_wb_after_flush: assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
        flush_i |=> !wb_vld_o);

endmodule

// ==== load_align.sv ====
// Load result alignment
// Word select, byte or half extraction, sign or zero extension

`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
(
    input  logic       from_io_i,
    input  word_t      io_data_i,
    input  dword_t     ram_data_i,
    input  logic [2:0] addr_low_i,
    input  load_op_t   op_i,
    output word_t      result_o
);

    word_t       sel_word;
    word_t       shifted;
    logic [15:0] half_data;

    // Address bit 2 picks the upper half of the SRAM line
    assign sel_word  = from_io_i ? io_data_i :
                       (addr_low_i[2] ? ram_data_i[63:32] : ram_data_i[31:0]);
    assign shifted   = sel_word >> {addr_low_i[1:0], 3'b000};
    assign half_data = addr_low_i[1] ? sel_word[31:16] : sel_word[15:0];

    always_comb begin
        case (op_i[1:0])
            2'd0: begin
                if (op_i[2]) begin
                    result_o = {24'h000000, shifted[7:0]};
                end else begin
                    result_o = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            2'd1: begin
                if (op_i[2]) begin
                    result_o = {16'h0000, half_data};
                end else begin
                    result_o = {{16{half_data[15]}}, half_data};
                end
            end
            // Full word, size 3 treated the same
            default: result_o = sel_word;
        endcase
    end

endmodule

// ==== load_data_ram.sv ====
// Data SRAM for cached loads, 512 lines of 64 bits
// One write port and one read port with registered output

`timescale 1ns/1ps

module load_data_ram
    import lsu_pkg::*;
(
    input  logic       core_clock_i,
    input  logic       wr_en_i,
    input  ram_index_t wr_index_i,
    input  dword_t     wr_data_i,
    input  logic       rd_en_i,
    input  ram_index_t rd_index_i,
    output dword_t     rd_data_o
);

    localparam int LINES = 1 << $bits(ram_index_t);

    dword_t mem [LINES];

    always_ff @(posedge core_clock_i) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= wr_data_i;
        end
    end

    // Read data shows the cycle after rd_en_i
    always_ff @(posedge core_clock_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule

// ==== load_fifo.sv ====
// Synchronous FIFO with flush
// Circular buffer, pointers carry an extra wrap bit to tell full from empty

`timescale 1ns/1ps

module load_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             core_clock_i,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] head_data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;

    assign head_data_o = mem[rd_ptr[PTR_W-1:0]];
    assign empty_o     = (wr_ptr == rd_ptr);
    // Same slot, opposite lap
    assign full_o      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                         (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    always_ff @(posedge core_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (push_i && !flush_i) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_data_i;
        end
    end

    a_no_overflow: assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
        push_i && !flush_i |-> !full_o);
    a_no_underflow: assert property (@(posedge core_clock_i) disable iff (!arst_n_i)
        pop_i && !flush_i |-> !empty_o);

endmodule

// ==== load_skid_buffer.sv ====
// One-entry skid buffer for the load request path
// Passes requests through when empty, holds one when the consumer stalls

`timescale 1ns/1ps

module load_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  logic             core_clock_i,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic             in_vld_i,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             stall_i,
    output logic             busy_o,
    output logic             out_vld_o,
    output logic [WIDTH-1:0] out_data_o
);

    logic             full;
    logic [WIDTH-1:0] held_data;

    // Held entry has priority over the live input
    assign out_vld_o  = full | in_vld_i;
    assign out_data_o = full ? held_data : in_data_i;
    assign busy_o     = full;

    always_ff @(posedge core_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full <= 1'b0;
        end else if (flush_i) begin
            full <= 1'b0;
        end else if (!full && in_vld_i && stall_i) begin
            full <= 1'b1;
        end else if (full && !stall_i) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (!full && in_vld_i && stall_i) begin
            held_data <= in_data_i;
        end
    end

endmodule

// ==== lsu_pkg.sv ====
// Shared definitions for the load side of the load/store unit
// Width types, I/O request state encoding, queue depth and request width

package lsu_pkg;

    // Bit 31 set selects I/O space
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // Only the low 5 bits are compared with the oldest tag
    typedef logic [5:0] rob_tag_t;
    typedef logic [4:0] oldest_tag_t;

    // Register 0 is never written
    typedef logic [5:0] phys_reg_t;

    // Bits 1:0 size (0 byte, 1 half, 2 word), bit 2 zero-extend
    typedef logic [2:0] load_op_t;

    // SRAM line index, address bits 11:3
    typedef logic [8:0] ram_index_t;

    typedef enum logic {
        IO_IDLE,
        IO_WAIT
    } io_state_t;

    localparam int IO_QUEUE_DEPTH = 4;

    // Packed request is {tag, op, address, destination}
    localparam int LOAD_REQ_WIDTH = 47;

    localparam int IO_SPACE_BIT = 31;

endpackage
